/* Bender.yml */
package:
  name: present_top

sources:
  - include_dirs:
      - hw
    files:
      - hw/present_pkg.sv
      - hw/present_key_pkg.sv
      - hw/key_schedule.sv
      - hw/present_round.sv
      - hw/present_datapath.sv
      - hw/present_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_present.sv

/* hw/key_schedule.sv */
// Sequential PRESENT-80 key expansion
// One key update and one table write per cycle

`timescale 1ns/1ps

`include "present_consts.svh"

module key_schedule (
    input  logic                       clk,
    input  logic                       rst,
    input  present_key_pkg::key_t      key_i,
    input  logic                       key_load_i,
    output present_pkg::rkey_table_t   round_keys_o,
    output logic                       keys_ready_o
);

    import present_pkg::*;
    import present_key_pkg::*;

    ks_state_t  state;
    round_idx_t round_idx;
    round_idx_t round_cnt;
    key_reg_u   key_reg;
    key_reg_u   rot_key;
    key_reg_u   next_key;

    // ----------------------------------------------------------
    // Key update for the next round
    // ----------------------------------------------------------
    assign round_cnt = round_idx + round_idx_t'(1); // Counter runs one ahead of the table index

    always_comb begin
        rot_key = {key_reg[18:0], key_reg[`PRESENT_KEY_W-1:19]}; // Rotate left by 61
        next_key = rot_key;
        next_key.upd.top_nib = sbox_fwd(rot_key.upd.top_nib);
        next_key.upd.rest[19:15] = rot_key.upd.rest[19:15] ^ round_cnt;
    end

    // ----------------------------------------------------------
    // Schedule FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            round_idx <= '0;
        end else if (key_load_i) begin
            state <= EXPAND; // A new load restarts from any state
            round_idx <= '0;
        end else if (state == EXPAND) begin
            round_idx <= round_cnt;
            if (round_idx == round_idx_t'(`PRESENT_ROUNDS)) begin
                state <= READY; // Last entry written on this edge
            end
        end
    end

    // Key register and table
    always_ff @(posedge clk) begin
        if (key_load_i) begin
            key_reg <= key_i;
        end else if (state == EXPAND) begin
            key_reg <= next_key;
            round_keys_o[round_idx] <= key_reg.ext.rkey;
        end
    end

    assign keys_ready_o = (state == READY);

endmodule

/* hw/present_consts.svh */
// Width and count constants of the PRESENT-80 cipher core
// Include guard keeps the macros to a single definition

`ifndef PRESENT_CONSTS_SVH
`define PRESENT_CONSTS_SVH

// ----------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------
`define PRESENT_BLOCK_W 64    // Cipher state and round key
`define PRESENT_KEY_W 80      // Full key register
`define PRESENT_NIBBLE_W 4    // S-box input and output

// ----------------------------------------------------------
// Schedule and round counts
// ----------------------------------------------------------
`define PRESENT_ROUNDS 31     // Full rounds after whitening
`define PRESENT_NUM_RKEYS 32  // Whitening key plus one per round

`endif

/* hw/present_datapath.sv */
// Unrolled PRESENT datapath for one direction
// Whitening key add followed by 31 chained rounds

`timescale 1ns/1ps

`include "present_consts.svh"

module present_datapath #(
    parameter bit INVERSE = 1'b0
) (
    input  present_pkg::block_t      block_i,
    input  present_pkg::rkey_table_t round_keys_i,
    output present_pkg::block_t      block_o
);

    import present_pkg::*;

    // Decryption whitens with the last key and walks the table downwards
    localparam int WHITEN_IDX = INVERSE ? `PRESENT_ROUNDS : 0;

    block_t [`PRESENT_ROUNDS:0] stage;

    assign stage[0] = block_i ^ round_keys_i[WHITEN_IDX];

    for (genvar r = 0; r < `PRESENT_ROUNDS; r++) begin : g_round
        localparam int KEY_IDX = INVERSE ? (`PRESENT_ROUNDS - 1 - r) : (r + 1);
        present_round #(.INVERSE(INVERSE)) u_round (
            .block_i    (stage[r]),
            .round_key_i(round_keys_i[KEY_IDX]),
            .block_o    (stage[r+1])
        );
    end

    assign block_o = stage[`PRESENT_ROUNDS];

endmodule

/* hw/present_key_pkg.sv */
// Key schedule types
// Key register union with update and extraction views
// Round index type and schedule FSM states

`include "present_consts.svh"

package present_key_pkg;

    typedef logic [`PRESENT_KEY_W-1:0] key_t;

    // One word decoded two ways over the same 80 bits
    typedef union packed {
        struct packed {
            logic [`PRESENT_NIBBLE_W-1:0] top_nib;                // Goes through the S-box
            logic [`PRESENT_KEY_W-`PRESENT_NIBBLE_W-1:0] rest;    // Holds the counter field
        } upd;
        struct packed {
            present_pkg::block_t rkey;                            // Current round key
            logic [`PRESENT_KEY_W-`PRESENT_BLOCK_W-1:0] tail;
        } ext;
    } key_reg_u;

    typedef logic [$clog2(`PRESENT_NUM_RKEYS)-1:0] round_idx_t;

    typedef enum logic [1:0] {
        IDLE,
        EXPAND,
        READY
    } ks_state_t;

endpackage

/* hw/present_pkg.sv */
// Cipher block and round-key table types
// Forward and inverse S-box lookups
// Forward and inverse bit permutation layers

`include "present_consts.svh"

package present_pkg;

    typedef logic [`PRESENT_BLOCK_W-1:0] block_t;
    typedef block_t [`PRESENT_NUM_RKEYS-1:0] rkey_table_t;

    // ----------------------------------------------------------
    // S-box tables with S(n) in nibble n of each word
    // ----------------------------------------------------------
    localparam logic [15:0][`PRESENT_NIBBLE_W-1:0] SBOX_FWD = 64'h21748FE3DA09B65C;
    localparam logic [15:0][`PRESENT_NIBBLE_W-1:0] SBOX_INV = 64'hA970364BD21C8FE5;

    function automatic logic [`PRESENT_NIBBLE_W-1:0] sbox_fwd(
        input logic [`PRESENT_NIBBLE_W-1:0] din
    );
        return SBOX_FWD[din];
    endfunction

    function automatic logic [`PRESENT_NIBBLE_W-1:0] sbox_inv(
        input logic [`PRESENT_NIBBLE_W-1:0] din
    );
        return SBOX_INV[din];
    endfunction

    // ----------------------------------------------------------
    // Bit permutation moving bit i to 16*i mod 63
    // ----------------------------------------------------------
    function automatic block_t p_layer_fwd(input block_t din);
        block_t dout;
        dout[`PRESENT_BLOCK_W-1] = din[`PRESENT_BLOCK_W-1]; // Top bit is a fixed point
        for (int i = 0; i < `PRESENT_BLOCK_W - 1; i++) begin
            dout[(i * (`PRESENT_BLOCK_W / `PRESENT_NIBBLE_W)) % (`PRESENT_BLOCK_W - 1)] = din[i];
        end
        return dout;
    endfunction

    function automatic block_t p_layer_inv(input block_t din);
        block_t dout;
        dout[`PRESENT_BLOCK_W-1] = din[`PRESENT_BLOCK_W-1];
        for (int i = 0; i < `PRESENT_BLOCK_W - 1; i++) begin
            dout[i] = din[(i * (`PRESENT_BLOCK_W / `PRESENT_NIBBLE_W)) % (`PRESENT_BLOCK_W - 1)];
        end
        return dout;
    endfunction

endpackage

/* hw/present_round.sv */
// One PRESENT round, forward or inverse
// Forward is S-layer, P-layer, key add
// Inverse is inverse P-layer, inverse S-layer, key add

`timescale 1ns/1ps

`include "present_consts.svh"

module present_round #(
    parameter bit INVERSE = 1'b0
) (
    input  present_pkg::block_t block_i,
    input  present_pkg::block_t round_key_i,
    output present_pkg::block_t block_o
);

    import present_pkg::*;

    localparam int NIBBLES = `PRESENT_BLOCK_W / `PRESENT_NIBBLE_W;

    block_t pre_sub;
    block_t post_sub;
    block_t mixed;

    always_comb begin
        pre_sub = INVERSE ? p_layer_inv(block_i) : block_i;
        for (int n = 0; n < NIBBLES; n++) begin
            if (INVERSE) begin
                post_sub[n*`PRESENT_NIBBLE_W +: `PRESENT_NIBBLE_W] =
                    sbox_inv(pre_sub[n*`PRESENT_NIBBLE_W +: `PRESENT_NIBBLE_W]);
            end else begin
                post_sub[n*`PRESENT_NIBBLE_W +: `PRESENT_NIBBLE_W] =
                    sbox_fwd(pre_sub[n*`PRESENT_NIBBLE_W +: `PRESENT_NIBBLE_W]);
            end
        end
        mixed = INVERSE ? post_sub : p_layer_fwd(post_sub);
    end

    assign block_o = mixed ^ round_key_i;

endmodule

/* hw/present_top.sv */
// PRESENT-80 core top level
// Key schedule, encrypt and decrypt datapaths, registered output stage

`timescale 1ns/1ps

module present_top (
    input  logic                   clk,
    input  logic                   rst,
    input  present_key_pkg::key_t  key_i,
    input  logic                   key_load_i,
    input  present_pkg::block_t    block_i,
    input  logic                   block_valid_i,
    input  logic                   decrypt_i,
    output logic                   keys_ready_o,
    output present_pkg::block_t    block_o,
    output logic                   block_valid_o
);

    import present_pkg::*;

    rkey_table_t round_keys;
    block_t      enc_block;
    block_t      dec_block;
    logic        keys_ready;
    logic        accept;

    key_schedule u_key_schedule (
        .clk         (clk),
        .rst         (rst),
        .key_i       (key_i),
        .key_load_i  (key_load_i),
        .round_keys_o(round_keys),
        .keys_ready_o(keys_ready)
    );

    present_datapath #(.INVERSE(1'b0)) u_enc (
        .block_i     (block_i),
        .round_keys_i(round_keys),
        .block_o     (enc_block)
    );

    present_datapath #(.INVERSE(1'b1)) u_dec (
        .block_i     (block_i),
        .round_keys_i(round_keys),
        .block_o     (dec_block)
    );

    // ----------------------------------------------------------
    // Output stage
    // ----------------------------------------------------------
    assign accept = block_valid_i & keys_ready; // Blocks before the table is full are dropped
    assign keys_ready_o = keys_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            block_valid_o <= 1'b0;
        end else begin
            block_valid_o <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            block_o <= decrypt_i ? dec_block : enc_block;
        end
    end

endmodule

/* present_top.f */
+incdir+hw
+incdir+sim
hw/present_pkg.sv
hw/present_key_pkg.sv
hw/key_schedule.sv
hw/present_round.sv
hw/present_datapath.sv
hw/present_top.sv
sim/tb_present.sv

/* sim/present_model.svh */
// Reference model of the PRESENT-80 cipher
// Key expansion, encryption and decryption on plain bit vectors

`ifndef PRESENT_MODEL_SVH
`define PRESENT_MODEL_SVH

typedef logic [31:0][63:0] model_rk_t;

function automatic logic [3:0] model_sbox(input logic [3:0] x);
    logic [3:0] tbl [0:15] = '{4'hC, 4'h5, 4'h6, 4'hB, 4'h9, 4'h0, 4'hA, 4'hD,
                               4'h3, 4'hE, 4'hF, 4'h8, 4'h4, 4'h7, 4'h1, 4'h2};
    return tbl[x];
endfunction

// Inverse found by searching the forward table
function automatic logic [3:0] model_sbox_inv(input logic [3:0] y);
    for (int x = 0; x < 16; x++) begin
        if (model_sbox(4'(x)) == y) return 4'(x);
    end
    return 4'h0;
endfunction

function automatic logic [63:0] model_sub(input logic [63:0] din, input bit inverse);
    logic [63:0] dout;
    for (int n = 0; n < 16; n++) begin
        dout[4*n +: 4] = inverse ? model_sbox_inv(din[4*n +: 4]) : model_sbox(din[4*n +: 4]);
    end
    return dout;
endfunction

function automatic logic [63:0] model_perm(input logic [63:0] din, input bit inverse);
    logic [63:0] dout;
    int          dst;
    for (int i = 0; i < 64; i++) begin
        dst = 16 * (i % 4) + i / 4; // Same as 16*i mod 63 with bit 63 fixed
        if (inverse) dout[i] = din[dst];
        else dout[dst] = din[i];
    end
    return dout;
endfunction

function automatic model_rk_t model_expand(input logic [79:0] key);
    model_rk_t   rk;
    logic [79:0] k;
    k = key;
    rk[0] = k[79:16];
    for (int r = 1; r < 32; r++) begin
        k = {k[18:0], k[79:19]};
        k[79:76] = model_sbox(k[79:76]);
        k[19:15] = k[19:15] ^ 5'(r);
        rk[r] = k[79:16];
    end
    return rk;
endfunction

function automatic logic [63:0] model_encrypt(input logic [63:0] pt, input model_rk_t rk);
    logic [63:0] s;
    s = pt;
    for (int r = 0; r < 31; r++) begin
        s = model_perm(model_sub(s ^ rk[r], 1'b0), 1'b0);
    end
    return s ^ rk[31];
endfunction

function automatic logic [63:0] model_decrypt(input logic [63:0] ct, input model_rk_t rk);
    logic [63:0] s;
    s = ct ^ rk[31];
    for (int r = 30; r >= 0; r--) begin
        s = model_sub(model_perm(s, 1'b1), 1'b1) ^ rk[r];
    end
    return s;
endfunction

`endif

/* sim/tb_present.sv */
// Testbench for the PRESENT-80 core
// Known answers, random encryption, round trips and dropped blocks

`timescale 1ns/1ps

module tb_present;

    `include "present_model.svh"

    localparam int MAX_CYCLES = 5 * 40 + 200 * 2 + 200;
    localparam int NUM_BLOCKS = 40;

    logic        clk, rst, key_load_i, block_valid_i, decrypt_i;
    logic [79:0] key_i;
    logic [63:0] block_i, block_o;
    logic        keys_ready_o, block_valid_o;

    model_rk_t   ref_keys;
    logic [63:0] exp_block;
    logic        exp_valid, key_loaded;
    int          ready_wait;
    logic [63:0] in_q[$], out_q[$], pt_q[$];
    string       test_name = "none";
    int          test_errs, total_errs, tests_run, tests_failed;
    int          cycles = 0;
    integer      seed;

    present_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .key_i        (key_i),
        .key_load_i   (key_load_i),
        .block_i      (block_i),
        .block_valid_i(block_valid_i),
        .decrypt_i    (decrypt_i),
        .keys_ready_o (keys_ready_o),
        .block_o      (block_o),
        .block_valid_o(block_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic void count_error();
        test_errs++;
        total_errs++;
    endfunction

    // ------------------------------------------------------------
    // Comparison process at the falling edge
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (rst !== 1'b0) begin
            exp_valid = 1'b0;
            key_loaded = 1'b0;
            ready_wait = 0;
        end else begin
            if (ready_wait > 0) ready_wait--;
            assert (block_valid_o === exp_valid) else begin
                $display("FAILED %s: block_valid_o expected %b, actual %b",
                         test_name, exp_valid, block_valid_o);
                count_error();
            end
            if (block_valid_o === 1'b1) begin
                if (exp_valid) begin
                    assert (block_o === exp_block) else begin
                        $display("FAILED %s: expected %h, actual %h",
                                 test_name, exp_block, block_o);
                        count_error();
                    end
                end
                out_q.push_back(block_o);
            end
            assert (keys_ready_o === (key_loaded && ready_wait == 0)) else begin
                $display("FAILED %s: keys_ready_o expected %b, actual %b",
                         test_name, key_loaded && ready_wait == 0, keys_ready_o);
                count_error();
            end
            exp_valid = block_valid_i && key_loaded && ready_wait == 0; // Taken at the next edge
            if (exp_valid) begin
                exp_block = decrypt_i ? model_decrypt(block_i, ref_keys)
                                      : model_encrypt(block_i, ref_keys);
            end
            if (key_load_i) begin
                ref_keys = model_expand(key_i);
                ready_wait = 33; // Load edge plus 32 table writes
                key_loaded = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------
    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
        out_q.delete();
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs > 0) tests_failed++;
        $display("Test %-12s %s (%0d errors)", test_name, test_errs ? "FAIL" : "ok", test_errs);
    endtask

    task automatic strobe_key(input logic [79:0] key);
        @(posedge clk);
        key_i <= key;
        key_load_i <= 1'b1;
        @(posedge clk);
        key_load_i <= 1'b0;
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        @(negedge clk);
        while (keys_ready_o !== 1'b1 && waited < 60) begin
            @(negedge clk);
            waited++;
        end
        assert (keys_ready_o === 1'b1) else begin
            $display("Key expansion did not finish within 60 cycles in %s", test_name);
            count_error();
        end
    endtask

    task automatic send_batch(input logic dec);
        foreach (in_q[i]) begin
            @(posedge clk);
            block_i <= in_q[i];
            block_valid_i <= 1'b1;
            decrypt_i <= dec;
        end
        @(posedge clk);
        block_valid_i <= 1'b0;
    endtask

    task automatic wait_outputs(input int n);
        int waited;
        waited = 0;
        while (out_q.size() < n && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        assert (out_q.size() == n) else begin
            $display("FAILED %s: result count expected %0d, actual %0d",
                     test_name, n, out_q.size());
            count_error();
        end
    endtask

    task automatic run_kat(input string name, input logic [79:0] key, input logic [63:0] ct);
        start_test(name);
        strobe_key(key);
        wait_ready();
        in_q = '{64'h0};
        send_batch(1'b0);
        wait_outputs(1);
        assert (out_q.size() == 1 && out_q[0] === ct) else begin
            $display("FAILED %s: expected %h, actual %h", name, ct, out_q[0]);
            count_error();
        end
        end_test();
    endtask

    task automatic fill_random(input int n);
        in_q.delete();
        repeat (n) in_q.push_back({$random(seed), $random(seed)});
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        seed = 32'h80a1;
        rst = 1'b1;
        key_load_i = 1'b0;
        block_valid_i = 1'b0;
        decrypt_i = 1'b0;
        key_i = '0;
        block_i = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        start_test("reset");
        in_q = '{64'h0123_4567_89ab_cdef};
        send_batch(1'b0); // No key yet, so nothing may come out
        repeat (5) @(negedge clk);
        assert (out_q.size() == 0) else begin
            $display("A block came out before any key was loaded");
            count_error();
        end
        end_test();

        run_kat("kat_zero", 80'h0, 64'h5579C1387B228445);
        run_kat("kat_ones", {80{1'b1}}, 64'hE72C46C0F5945049);

        for (int k = 0; k < 2; k++) begin
            start_test($sformatf("encrypt_%0d", k));
            strobe_key({$random(seed), $random(seed), 16'($random(seed))});
            wait_ready();
            fill_random(NUM_BLOCKS);
            pt_q = in_q;
            send_batch(1'b0);
            wait_outputs(NUM_BLOCKS);
            end_test();

            in_q = out_q; // Ciphertexts of the previous batch
            start_test($sformatf("round_trip_%0d", k));
            send_batch(1'b1);
            wait_outputs(NUM_BLOCKS);
            foreach (out_q[i]) begin
                assert (out_q[i] === pt_q[i]) else begin
                    $display("FAILED %s: expected %h, actual %h", test_name, pt_q[i], out_q[i]);
                    count_error();
                end
            end
            end_test();
        end

        start_test("dropped");
        strobe_key({$random(seed), $random(seed), 16'($random(seed))});
        fill_random(4);
        send_batch(1'b0); // Expansion still running
        wait_ready();
        assert (out_q.size() == 0) else begin
            $display("Blocks sent during key expansion were not dropped");
            count_error();
        end
        send_batch(1'b0);
        wait_outputs(4);
        end_test();

        $display("Tests run: %0d, tests with errors: %0d, total errors: %0d",
                 tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
